//--- source/besm_bus_pkg.sv
/* Shared definitions for the external bus: word width, bus operation codes,
   bus I/O register index and the semaphore bit set by read-modify-write */
package besm_bus_pkg;

    localparam int WORD_BITS     = 64;  // Memory and register word width
    localparam int SEMAPHORE_BIT = 55;  // Set by RDMWR on write back

    // Bus operations as issued by the processor
    typedef enum logic [3:0] {
        IDLE  = 4'd0,   // Nothing to do
        CCRD  = 4'd1,   // Instruction cache read, no bus cycles
        CCWR  = 4'd2,   // Instruction cache write, no bus cycles
        DCRD  = 4'd3,   // Operand cache read, no bus cycles
        DCWR  = 4'd4,   // Operand cache write, no bus cycles
        FETCH = 4'd8,   // Instruction fetch into RG1
        DRD   = 4'd9,   // Operand read into RG2
        DWR   = 4'd10,  // Result write from RG3
        RDMWR = 4'd11,  // Atomic read, set semaphore, write back
        BTRWR = 4'd12,  // Block transfer write
        BTRRD = 4'd13,  // Block transfer read
        BICLR = 4'd14,  // Clear bus interrupts, no bus cycles
        BIRD  = 4'd15   // Poll bus interrupts, no bus cycles
    } bus_op_t;

    // Bus I/O register selected by the arbiter
    typedef enum logic [1:0] {
        ADDR  = 2'd0,   // RG0 physical address
        CMD   = 2'd1,   // RG1 fetched instruction
        RDATA = 2'd2,   // RG2 loaded operand
        WDATA = 2'd3    // RG3 data to store
    } reg_index_t;

endpackage

//--- source/bus_arbiter.sv
/* Bus arbiter: latches the requested bus operation and walks it step by step,
   driving register-port and memory strobes until done rises again */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     request,  // One-cycle start pulse
    input  logic                     suspend,  // Abort and hold
    input  besm_bus_pkg::bus_op_t    req_op,   // Operation, sampled with request

    output besm_bus_pkg::reg_index_t arx,      // Bus I/O register index
    output logic                     ecx,      // Register port enable
    output logic                     wrx,      // Register capture from memory
    output logic                     astb,     // Memory address strobe
    output logic                     atomic,   // RDMWR in progress
    output logic                     rd,       // Memory read
    output logic                     wr,       // Memory write
    output logic                     done      // Level, high when idle
);

    localparam logic [2:0] MAX_STEP = 3'd7;    // Counter stops here

    logic [2:0]            step;               // Position in the sequence
    besm_bus_pkg::bus_op_t opcode;             // Latched operation
    logic                  batch_mode;         // Previous op was a block transfer
    logic                  block;              // Latched op is BTRWR or BTRRD
    logic                  skip;               // Address step left out
    logic [2:0]            phase;              // Step as seen by the sequence
    logic [2:0]            seq_len;            // Steps in the current sequence
    logic                  active;             // Sequence still running

    always_ff @(posedge clk) begin
        if (reset)
            step <= 3'd0;
        else if (request)
            step <= 3'd0;                      // Restart on every request
        else if (!done && !suspend && step != MAX_STEP)
            step <= step + 3'd1;
    end

    always_ff @(posedge clk) begin
        if (reset || suspend)
            opcode <= besm_bus_pkg::IDLE;      // Suspend drops the operation
        else if (request)
            opcode <= req_op;
    end

    // Block mode survives only across back-to-back block transfers
    always_ff @(posedge clk) begin
        if (reset)
            batch_mode <= 1'b0;
        else if (done && !suspend)
            batch_mode <= block;               // Updated once the op has finished
    end

    assign block  = (opcode == besm_bus_pkg::BTRWR) || (opcode == besm_bus_pkg::BTRRD);
    assign skip   = block && batch_mode;       // Counter already points at next word
    assign phase  = step + {2'b00, skip};
    assign atomic = (opcode == besm_bus_pkg::RDMWR);

    always_comb begin
        seq_len = 3'd0;                        // No bus cycles unless listed
        arx     = besm_bus_pkg::RDATA;
        wrx     = 1'b0;
        astb    = 1'b0;
        rd      = 1'b0;
        wr      = 1'b0;

        case (opcode)
            besm_bus_pkg::FETCH,
            besm_bus_pkg::DRD,
            besm_bus_pkg::BTRRD: begin
                seq_len = 3'd3 - {2'b00, skip};
                if (opcode == besm_bus_pkg::FETCH)
                    arx = besm_bus_pkg::CMD;   // Instruction lands in RG1
                if (phase == 3'd0)
                    arx = besm_bus_pkg::ADDR;
                astb = (phase == 3'd0);        // Send address
                rd   = (phase == 3'd1);        // Get data
                wrx  = (phase == 3'd2);        // Capture word
            end

            besm_bus_pkg::DWR,
            besm_bus_pkg::BTRWR: begin
                seq_len = 3'd3 - {2'b00, skip};
                arx     = besm_bus_pkg::WDATA;
                if (phase == 3'd0)
                    arx = besm_bus_pkg::ADDR;
                astb = (phase == 3'd0);        // Send address
                wr   = (phase == 3'd2);        // Phase 1 only puts RG3 on the bus
            end

            besm_bus_pkg::RDMWR: begin
                seq_len = 3'd5;
                if (phase == 3'd0)
                    arx = besm_bus_pkg::ADDR;
                // Counter moved on after the read, so strobe the address again
                astb = (phase == 3'd0) || (phase == 3'd3);
                rd   = (phase == 3'd1);        // Read old word
                wrx  = (phase == 3'd2);        // Keep it in RG2
                wr   = (phase == 3'd4);        // Write back with semaphore set
            end

            besm_bus_pkg::IDLE,
            besm_bus_pkg::CCRD,
            besm_bus_pkg::CCWR,
            besm_bus_pkg::DCRD,
            besm_bus_pkg::DCWR,
            besm_bus_pkg::BICLR,
            besm_bus_pkg::BIRD: begin
                // Cache and interrupt ops finish with no bus cycles
            end

            default: begin
            end
        endcase

        active = !suspend && (step < seq_len);
        if (!active) begin                     // Past the end or aborted
            arx  = besm_bus_pkg::RDATA;
            wrx  = 1'b0;
            astb = 1'b0;
            rd   = 1'b0;
            wr   = 1'b0;
        end
        ecx  = active;
        done = !active;
    end

endmodule

//--- source/busio_registers.sv
/* Bus I/O registers RG0..RG3 between processor and memory; the arbiter picks
   one for capture or for driving the outgoing data word */
`timescale 1ns/1ps

module busio_registers #(
    parameter int ADDR_WIDTH = 8               // Memory address bits
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                request,    // Load RG0 and RG3
    input  logic                                ecx,        // Register port enable
    input  logic                                wrx,        // Capture from memory
    input  logic                                atomic,     // Force semaphore bit
    input  besm_bus_pkg::reg_index_t            arx,        // Selected register
    input  logic [ADDR_WIDTH-1:0]               cpu_addr,
    input  logic [besm_bus_pkg::WORD_BITS-1:0]  cpu_wdata,
    input  logic [besm_bus_pkg::WORD_BITS-1:0]  mem_rdata,

    output logic [ADDR_WIDTH-1:0]               bus_addr,   // RG0 to memory
    output logic [besm_bus_pkg::WORD_BITS-1:0]  bus_wdata,  // Selected register out
    output logic [besm_bus_pkg::WORD_BITS-1:0]  cmd_word,   // RG1 to processor
    output logic [besm_bus_pkg::WORD_BITS-1:0]  data_word   // RG2 to processor
);

    logic [ADDR_WIDTH-1:0]              rg0;       // Address
    logic [besm_bus_pkg::WORD_BITS-1:0] rg1;       // Fetched instruction
    logic [besm_bus_pkg::WORD_BITS-1:0] rg2;       // Loaded operand
    logic [besm_bus_pkg::WORD_BITS-1:0] rg3;       // Store data
    logic [besm_bus_pkg::WORD_BITS-1:0] sel_word;  // Register picked by arx
    logic                               capture;

    assign capture = ecx && wrx;

    always_ff @(posedge clk) begin
        if (request)
            rg0 <= cpu_addr;
        else if (capture && arx == besm_bus_pkg::ADDR)
            rg0 <= mem_rdata[ADDR_WIDTH-1:0];  // Low bits only
    end

    always_ff @(posedge clk) begin
        if (reset)
            rg1 <= '0;
        else if (capture && arx == besm_bus_pkg::CMD)
            rg1 <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset)
            rg2 <= '0;
        else if (capture && arx == besm_bus_pkg::RDATA)
            rg2 <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (request)
            rg3 <= cpu_wdata;
        else if (capture && arx == besm_bus_pkg::WDATA)
            rg3 <= mem_rdata;
    end

    always_comb begin
        sel_word = '0;
        case (arx)
            besm_bus_pkg::ADDR:  sel_word[ADDR_WIDTH-1:0] = rg0;  // Zero extended
            besm_bus_pkg::CMD:   sel_word = rg1;
            besm_bus_pkg::RDATA: sel_word = rg2;
            besm_bus_pkg::WDATA: sel_word = rg3;
            default:             sel_word = rg3;
        endcase
    end

    // RDMWR writes the old word back marked as taken, RG2 keeps it as read
    always_comb begin
        bus_wdata = sel_word;
        if (atomic)
            bus_wdata[besm_bus_pkg::SEMAPHORE_BIT] = 1'b1;
    end

    assign bus_addr  = rg0;
    assign cmd_word  = rg1;
    assign data_word = rg2;

endmodule

//--- source/memory_port.sv
/* Memory behind the external bus: address counter loaded by the address strobe
   and a synchronous word array read and written at the counter */
`timescale 1ns/1ps

module memory_port #(
    parameter int ADDR_WIDTH = 8               // Counter and array index bits
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                astb,       // Load counter from bus
    input  logic                                rd,         // Read at counter
    input  logic                                wr,         // Write at counter
    input  logic [ADDR_WIDTH-1:0]               bus_addr,
    input  logic [besm_bus_pkg::WORD_BITS-1:0]  bus_wdata,

    output logic [besm_bus_pkg::WORD_BITS-1:0]  mem_rdata   // Registered read word
);

    localparam int DEPTH = 1 << ADDR_WIDTH;    // Words in the array

    logic [ADDR_WIDTH-1:0]              addr_cnt;           // Current word address
    logic [besm_bus_pkg::WORD_BITS-1:0] mem [0:DEPTH-1];
    logic                               access;             // Read or write this cycle

    assign access = rd || wr;

    // Block transfers rely on the step after each access
    always_ff @(posedge clk) begin
        if (reset)
            addr_cnt <= '0;
        else if (astb)
            addr_cnt <= bus_addr;              // New transfer start
        else if (access)
            addr_cnt <= addr_cnt + 1'b1;       // Wraps at the top of memory
    end

    always_ff @(posedge clk) begin
        if (wr)
            mem[addr_cnt] <= bus_wdata;
    end

    always_ff @(posedge clk) begin
        if (rd)
            mem_rdata <= mem[addr_cnt];        // Holds until the next read
    end

endmodule

//--- source/bus_unit.sv
/* Top of the external bus side: arbiter, bus I/O registers and memory,
   driven by the processor request and returning fetched and loaded words */
`timescale 1ns/1ps

module bus_unit #(
    parameter int ADDR_WIDTH = 8               // Memory address bits, 4 to 16
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                request,    // One-cycle pulse
    input  logic                                suspend,    // Abort level
    input  besm_bus_pkg::bus_op_t               req_op,
    input  logic [ADDR_WIDTH-1:0]               cpu_addr,
    input  logic [besm_bus_pkg::WORD_BITS-1:0]  cpu_wdata,

    output logic                                done,       // High until next request
    output logic [besm_bus_pkg::WORD_BITS-1:0]  cmd_word,   // Fetched instruction
    output logic [besm_bus_pkg::WORD_BITS-1:0]  data_word   // Loaded operand
);

    besm_bus_pkg::reg_index_t           arx;
    logic                               ecx;
    logic                               wrx;
    logic                               astb;
    logic                               atomic;
    logic                               rd;
    logic                               wr;
    logic [ADDR_WIDTH-1:0]              bus_addr;
    logic [besm_bus_pkg::WORD_BITS-1:0] bus_wdata;
    logic [besm_bus_pkg::WORD_BITS-1:0] mem_rdata;

    bus_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .suspend (suspend),
        .req_op  (req_op),
        .arx     (arx),
        .ecx     (ecx),
        .wrx     (wrx),
        .astb    (astb),
        .atomic  (atomic),
        .rd      (rd),
        .wr      (wr),
        .done    (done)
    );

    busio_registers #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_registers (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .ecx       (ecx),
        .wrx       (wrx),
        .atomic    (atomic),
        .arx       (arx),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .mem_rdata (mem_rdata),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .cmd_word  (cmd_word),
        .data_word (data_word)
    );

    memory_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_memory (
        .clk       (clk),
        .reset     (reset),
        .astb      (astb),
        .rd        (rd),
        .wr        (wr),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- verification/bus_unit_tb.sv
/* Directed testbench for the bus unit: issues bus operations from the processor
   side and checks returned words and request-to-done latency */
`timescale 1ns/1ps

module bus_unit_tb;

    localparam int ADDR_WIDTH      = 8;
    localparam int WORD_BITS       = besm_bus_pkg::WORD_BITS;
    localparam int CLK_PERIOD      = 100;         // ns
    localparam int DRIVE_DELAY     = 5;           // Inputs change this long after the edge
    localparam int DONE_LIMIT      = 20;          // Edges to wait for done
    localparam int WATCHDOG_CYCLES = 600;         // Whole run with margin

    logic                  clk;
    logic                  reset;
    logic                  request;
    logic                  suspend;
    besm_bus_pkg::bus_op_t req_op;
    logic [ADDR_WIDTH-1:0] cpu_addr;
    logic [WORD_BITS-1:0]  cpu_wdata;
    logic                  done;
    logic [WORD_BITS-1:0]  cmd_word;
    logic [WORD_BITS-1:0]  data_word;

    integer               seed = 32'h1200;
    int                   error_count = 0;
    int                   check_count = 0;
    logic [WORD_BITS-1:0] first_word;             // Left at 8'h10 by the first test

    bus_unit #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .suspend   (suspend),
        .req_op    (req_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .done      (done),
        .cmd_word  (cmd_word),
        .data_word (data_word)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [WORD_BITS-1:0] random_word();
        return {$random(seed), $random(seed)};    // Two 32-bit draws
    endfunction

    task automatic compare_word(input logic [WORD_BITS-1:0] actual,
                                input logic [WORD_BITS-1:0] expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_latency(input int actual, input int expected, input string what);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("Fail at %0t: %s took %0d cycles expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic compare_level(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s is %b expected %b", $time, what, actual, expected);
        end
    endtask

    // Starts right after a drive point, returns at one; latency counts edges after E0
    task automatic bus_transfer(input besm_bus_pkg::bus_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                                input logic [WORD_BITS-1:0] wdata, input int exp_latency);
        int edges;
        edges     = 0;
        req_op    = op;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        request   = 1'b1;
        @(posedge clk);                           // Request edge E0
        #DRIVE_DELAY;
        request = 1'b0;
        req_op  = besm_bus_pkg::IDLE;
        while (!done && edges < DONE_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            edges++;
        end
        if (!done) begin
            error_count++;
            $display("done never rose within %0d cycles of a %s request", DONE_LIMIT, op.name());
        end
        compare_latency(edges, exp_latency, {op.name(), " latency"});
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_write_read();
        int errors_before;
        errors_before = error_count;
        compare_level(done, 1'b1, "done after reset");
        bus_transfer(besm_bus_pkg::IDLE, 8'h00, '0, 0);
        compare_level(done, 1'b1, "done under IDLE");
        first_word = random_word();
        bus_transfer(besm_bus_pkg::DWR, 8'h10, first_word, 3);
        bus_transfer(besm_bus_pkg::DRD, 8'h10, '0, 3);
        compare_word(data_word, first_word, "DRD after DWR");
        report_test("write_read", errors_before);
    endtask

    task automatic test_fetch();
        int                   errors_before;
        logic [WORD_BITS-1:0] instr;
        logic [WORD_BITS-1:0] data_before;
        errors_before = error_count;
        instr = random_word();
        bus_transfer(besm_bus_pkg::DWR, 8'h20, instr, 3);
        data_before = data_word;
        bus_transfer(besm_bus_pkg::FETCH, 8'h20, '0, 3);
        compare_word(cmd_word, instr, "FETCH cmd_word");
        compare_word(data_word, data_before, "data_word across FETCH");
        report_test("fetch", errors_before);
    endtask

    task automatic test_rdmwr();
        int                   errors_before;
        logic [WORD_BITS-1:0] old_word;
        logic [WORD_BITS-1:0] marked;
        errors_before = error_count;
        old_word = random_word();
        old_word[besm_bus_pkg::SEMAPHORE_BIT] = 1'b0;     // So the set bit shows
        marked = old_word;
        marked[besm_bus_pkg::SEMAPHORE_BIT] = 1'b1;
        bus_transfer(besm_bus_pkg::DWR, 8'h30, old_word, 3);
        bus_transfer(besm_bus_pkg::RDMWR, 8'h30, random_word(), 5);
        compare_word(data_word, old_word, "RDMWR old word");
        bus_transfer(besm_bus_pkg::DRD, 8'h30, '0, 3);
        compare_word(data_word, marked, "word after RDMWR");
        report_test("rdmwr", errors_before);
    endtask

    task automatic test_block();
        int                    errors_before;
        logic [WORD_BITS-1:0]  words [4];
        logic [ADDR_WIDTH-1:0] addr;
        errors_before = error_count;
        for (int i = 0; i < 4; i++)
            words[i] = random_word();
        for (int i = 0; i < 4; i++) begin
            addr = (i == 0) ? 8'h40 : 8'hc0 + 8'(i);      // Only the first address counts
            bus_transfer(besm_bus_pkg::BTRWR, addr, words[i], (i == 0) ? 3 : 2);
        end
        bus_transfer(besm_bus_pkg::DRD, 8'h10, '0, 3);     // Ends batch mode
        compare_word(data_word, first_word, "DRD between blocks");
        for (int i = 0; i < 4; i++) begin
            addr = (i == 0) ? 8'h40 : 8'hd0 + 8'(i);
            bus_transfer(besm_bus_pkg::BTRRD, addr, '0, (i == 0) ? 3 : 2);
            compare_word(data_word, words[i], $sformatf("BTRRD word %0d", i));
        end
        report_test("block", errors_before);
    endtask

    task automatic test_suspend();
        int                   errors_before;
        logic [WORD_BITS-1:0] kept;
        logic [WORD_BITS-1:0] lost;
        errors_before = error_count;
        kept = random_word();
        lost = ~kept;                             // Differs in every bit
        bus_transfer(besm_bus_pkg::DWR, 8'h50, kept, 3);
        req_op    = besm_bus_pkg::DWR;
        cpu_addr  = 8'h50;
        cpu_wdata = lost;
        request   = 1'b1;
        @(posedge clk);                           // E0
        #DRIVE_DELAY;
        request = 1'b0;
        req_op  = besm_bus_pkg::IDLE;
        compare_level(done, 1'b0, "done while DWR runs");
        @(posedge clk);                           // Step 1, address already sent
        #DRIVE_DELAY;
        suspend = 1'b1;
        #1;
        compare_level(done, 1'b1, "done as suspend rises");
        repeat (2) begin
            @(posedge clk);
            #DRIVE_DELAY;
            compare_level(done, 1'b1, "done under suspend");
        end
        suspend = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        compare_level(done, 1'b1, "done after suspend drops");
        bus_transfer(besm_bus_pkg::DRD, 8'h50, '0, 3);
        compare_word(data_word, kept, "word after aborted DWR");
        report_test("suspend", errors_before);
    endtask

    task automatic test_no_bus();
        int                    errors_before;
        besm_bus_pkg::bus_op_t ops [6];
        logic [WORD_BITS-1:0]  cmd_before;
        logic [WORD_BITS-1:0]  data_before;
        errors_before = error_count;
        ops[0] = besm_bus_pkg::CCRD;
        ops[1] = besm_bus_pkg::CCWR;
        ops[2] = besm_bus_pkg::DCRD;
        ops[3] = besm_bus_pkg::DCWR;
        ops[4] = besm_bus_pkg::BICLR;
        ops[5] = besm_bus_pkg::BIRD;
        cmd_before  = cmd_word;
        data_before = data_word;
        foreach (ops[i]) begin
            bus_transfer(ops[i], 8'h60 + 8'(i), random_word(), 0);   // Done at the request edge
            compare_word(cmd_word, cmd_before, {ops[i].name(), " cmd_word"});
            compare_word(data_word, data_before, {ops[i].name(), " data_word"});
        end
        report_test("no_bus", errors_before);
    endtask

    initial begin
        reset     = 1'b1;
        request   = 1'b0;
        suspend   = 1'b0;
        req_op    = besm_bus_pkg::IDLE;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_write_read();
        test_fetch();
        test_rdmwr();
        test_block();
        test_suspend();
        test_no_bus();

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- compile.f
source/besm_bus_pkg.sv
source/bus_arbiter.sv
source/busio_registers.sv
source/memory_port.sv
source/bus_unit.sv
verification/bus_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bus unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module bus_unit_tb \
    --Mdir obj_dir -o bus_unit_sim > build.log 2>&1 \
    && ./obj_dir/bus_unit_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "No pass message in simulation log"; exit 1; }
exit 0
